// File: Bender.yml
package:
  name: res_err

sources:
  - logic/res_err_pkg.sv
  - logic/word_pipe.sv
  - logic/channel_filter.sv
  - logic/interval_timer.sv
  - logic/res_err_datapath.sv
  - logic/tap_adapter.sv
  - logic/adapt_ctrl.sv
  - logic/res_err_top.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/res_err_assert.sv
      - testbench/res_err_tb.sv

// File: logic/adapt_ctrl.sv
`timescale 1ns/10ps

module adapt_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic adapt_en,
    input  logic done,
    output logic timer_load,
    output logic timer_count,
    output logic acc_en,
    output logic apply,
    output logic clear,
    output logic err_valid
);

    import res_err_pkg::*;

    adapt_state_t state;
    adapt_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILL;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FILL: begin
                // IDLE reloads the timer before the first interval
                if (done) begin
                    state_next = IDLE;
                end
            end
            IDLE: begin
                if (adapt_en) begin
                    state_next = ACCUM;
                end
            end
            ACCUM: begin
                if (!adapt_en) begin
                    state_next = IDLE;
                end else if (done) begin
                    state_next = APPLY;
                end
            end
            APPLY: state_next = adapt_en ? ACCUM : IDLE;
            default: state_next = FILL;
        endcase
    end

    // Every entry into ACCUM starts a full interval
    assign timer_load  = (state_next == ACCUM) && (state != ACCUM);
    assign timer_count = (state == FILL) || (state == ACCUM);

    assign acc_en    = (state == ACCUM) && adapt_en;
    assign apply     = (state == APPLY) && adapt_en;
    assign clear     = (state == IDLE);
    assign err_valid = (state != FILL);

endmodule

// File: logic/channel_filter.sv
`timescale 1ns/10ps

module channel_filter (
    input  res_err_pkg::sym_window_t window,
    input  res_err_pkg::taps_t       taps,
    output res_err_pkg::est_word_t   est
);

    import res_err_pkg::*;

    // Flattened stream position q maps to word q / lane_count, lane q % lane_count.
    // Lanes of the middle word sit at lane_count .. 2*lane_count-1.
    always_comb begin
        int   pos;
        sum_t sum;
        sym_t sym_v;
        tap_t tap_v;

        for (int i = 0; i < lane_count; i++) begin
            sum = '0;
            for (int j = 0; j < tap_count; j++) begin
                // Tap 0 looks one symbol ahead
                pos   = lane_count + i + 1 - j;
                sym_v = window[pos / lane_count][pos % lane_count];
                tap_v = taps[j];
                sum   = sum + sum_t'(tap_v) * sum_t'(sym_v);
            end
            est[i] = est_t'(sum >>> chan_shift);
        end
    end

endmodule

// File: logic/interval_timer.sv
`timescale 1ns/10ps

module interval_timer (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  res_err_pkg::timer_t load_value,
    input  logic                count,
    output logic                done
);

    import res_err_pkg::*;

    timer_t remaining;

    // Reset starts the pipeline fill wait
    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= timer_t'(fill_cycles);
        end else if (load) begin
            remaining <= load_value;
        end else if (count && remaining != '0) begin
            remaining <= remaining - timer_t'(1);
        end
    end

    assign done = (remaining == '0) && !load;

endmodule

// File: logic/res_err_datapath.sv
`timescale 1ns/10ps

module res_err_datapath (
    input  logic                     clk,
    input  logic                     rst,
    input  res_err_pkg::sym_word_t   sym_in,
    input  res_err_pkg::code_word_t  code_in,
    input  res_err_pkg::taps_t       taps,
    output res_err_pkg::err_word_t   err_out,
    output res_err_pkg::sym_word_t   sym_out,
    output res_err_pkg::sym_window_t sym_window
);

    import res_err_pkg::*;

    sym_window_t filt_window;
    est_word_t   est;
    code_word_t  code_aligned;
    err_word_t   err_next;

    // Symbol stages 2, 1, 0 as the filter window, newest word at the top
    always_ff @(posedge clk) begin
        if (rst) begin
            filt_window <= '0;
        end else begin
            filt_window <= {sym_in, filt_window[window_words-1:1]};
        end
    end

    channel_filter chan_filt_i (
        .window (filt_window),
        .taps   (taps),
        .est    (est)
    );

    // Codes wait for the lookahead word
    word_pipe #(
        .payload_t (code_word_t),
        .depth     (2)
    ) code_pipe_i (
        .clk  (clk),
        .rst  (rst),
        .din  (code_in),
        .dout (code_aligned)
    );

    always_comb begin
        est_t  est_v;
        code_t code_v;

        for (int i = 0; i < lane_count; i++) begin
            est_v       = est[i];
            code_v      = code_aligned[i];
            err_next[i] = err_t'(est_v) - err_t'(code_v);
        end
    end

    word_pipe #(
        .payload_t (err_word_t),
        .depth     (1)
    ) err_pipe_i (
        .clk  (clk),
        .rst  (rst),
        .din  (err_next),
        .dout (err_out)
    );

    // Window held one more cycle to line up with err_out
    word_pipe #(
        .payload_t (sym_window_t),
        .depth     (1)
    ) sym_pipe_i (
        .clk  (clk),
        .rst  (rst),
        .din  (filt_window),
        .dout (sym_window)
    );

    assign sym_out = sym_window[1];

endmodule

// File: logic/res_err_pkg.sv
package res_err_pkg;

    // Stream geometry
    localparam int lane_count   = 4;
    localparam int window_words = 3;

    localparam int sym_width  = 3;
    localparam int code_width = 8;

    // Channel estimate, tap 0 is the precursor and tap 1 the main cursor
    localparam int tap_count  = 4;
    localparam int tap_width  = 8;
    localparam int chan_shift = 2;

    localparam int sum_width = tap_width + sym_width + $clog2(tap_count);
    localparam int est_width = 12;
    localparam int err_width = 12;

    // Sign-sign LMS
    localparam int acc_width    = 10;
    localparam int adapt_period = 32;
    localparam int fill_cycles  = 2;
    localparam int timer_width  = $clog2(adapt_period);

    typedef logic signed [sym_width-1:0]  sym_t;
    typedef logic signed [code_width-1:0] code_t;
    typedef logic signed [tap_width-1:0]  tap_t;
    typedef logic signed [sum_width-1:0]  sum_t;
    typedef logic signed [est_width-1:0]  est_t;
    typedef logic signed [err_width-1:0]  err_t;
    typedef logic signed [acc_width-1:0]  acc_t;
    typedef logic [timer_width-1:0]       timer_t;

    typedef sym_t  [lane_count-1:0] sym_word_t;
    typedef code_t [lane_count-1:0] code_word_t;
    typedef est_t  [lane_count-1:0] est_word_t;
    typedef err_t  [lane_count-1:0] err_word_t;
    typedef tap_t  [tap_count-1:0]  taps_t;

    // Index 0 holds the oldest word
    typedef sym_word_t [window_words-1:0] sym_window_t;

    typedef enum logic [1:0] {
        FILL,
        IDLE,
        ACCUM,
        APPLY
    } adapt_state_t;

    // Highest index first, so this reads 0, 16, 64, 0 from tap 3 down
    localparam taps_t tap_init = {tap_t'(0), tap_t'(16), tap_t'(64), tap_t'(0)};

    localparam tap_t tap_max = tap_t'(2 ** (tap_width - 1) - 1);
    localparam tap_t tap_min = tap_t'(-(2 ** (tap_width - 1)));

    // Timer runs load value plus one cycles
    localparam timer_t adapt_reload = timer_t'(adapt_period - 1);

endpackage

// File: logic/res_err_top.sv
`timescale 1ns/10ps

module res_err_top (
    input  logic                    clk,
    input  logic                    rst,
    input  res_err_pkg::sym_word_t  sym_in,
    input  res_err_pkg::code_word_t code_in,
    input  logic                    adapt_en,
    output res_err_pkg::err_word_t  err_out,
    output res_err_pkg::sym_word_t  sym_out,
    output logic                    err_valid,
    output res_err_pkg::taps_t      taps
);

    import res_err_pkg::*;

    sym_window_t sym_window;
    logic        timer_load;
    logic        timer_count;
    logic        done;
    logic        acc_en;
    logic        apply;
    logic        clear;

    res_err_datapath datapath_i (
        .clk        (clk),
        .rst        (rst),
        .sym_in     (sym_in),
        .code_in    (code_in),
        .taps       (taps),
        .err_out    (err_out),
        .sym_out    (sym_out),
        .sym_window (sym_window)
    );

    tap_adapter adapter_i (
        .clk        (clk),
        .rst        (rst),
        .err_out    (err_out),
        .sym_window (sym_window),
        .acc_en     (acc_en),
        .apply      (apply),
        .clear      (clear),
        .taps       (taps)
    );

    adapt_ctrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .adapt_en    (adapt_en),
        .done        (done),
        .timer_load  (timer_load),
        .timer_count (timer_count),
        .acc_en      (acc_en),
        .apply       (apply),
        .clear       (clear),
        .err_valid   (err_valid)
    );

    interval_timer timer_i (
        .clk        (clk),
        .rst        (rst),
        .load       (timer_load),
        .load_value (adapt_reload),
        .count      (timer_count),
        .done       (done)
    );

endmodule

// File: logic/tap_adapter.sv
`timescale 1ns/10ps

module tap_adapter (
    input  logic                     clk,
    input  logic                     rst,
    input  res_err_pkg::err_word_t   err_out,
    input  res_err_pkg::sym_window_t sym_window,
    input  logic                     acc_en,
    input  logic                     apply,
    input  logic                     clear,
    output res_err_pkg::taps_t       taps
);

    import res_err_pkg::*;

    acc_t acc  [tap_count];
    acc_t corr [tap_count];

    // Sign-sign correlation of error with the symbol each tap multiplies
    always_comb begin
        int   pos;
        logic err_neg;
        logic sym_neg;
        sym_t sym_v;

        for (int j = 0; j < tap_count; j++) begin
            corr[j] = '0;
            for (int i = 0; i < lane_count; i++) begin
                pos     = lane_count + i + 1 - j;
                sym_v   = sym_window[pos / lane_count][pos % lane_count];
                err_neg = err_out[i][err_width-1];
                sym_neg = sym_v[sym_width-1];
                if (err_neg == sym_neg) begin
                    corr[j] = corr[j] + acc_t'(1);
                end else begin
                    corr[j] = corr[j] - acc_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            taps <= tap_init;
            for (int j = 0; j < tap_count; j++) begin
                acc[j] <= '0;
            end
        end else if (clear) begin
            for (int j = 0; j < tap_count; j++) begin
                acc[j] <= '0;
            end
        end else if (apply) begin
            for (int j = 0; j < tap_count; j++) begin
                // Step against the correlation, saturating
                if (acc[j] > 0 && taps[j] != tap_min) begin
                    taps[j] <= taps[j] - tap_t'(1);
                end else if (acc[j] < 0 && taps[j] != tap_max) begin
                    taps[j] <= taps[j] + tap_t'(1);
                end
                acc[j] <= '0;
            end
        end else if (acc_en) begin
            for (int j = 0; j < tap_count; j++) begin
                acc[j] <= acc[j] + corr[j];
            end
        end
    end

endmodule

// File: logic/word_pipe.sv
`timescale 1ns/10ps

module word_pipe #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < depth; s++) begin
                stage[s] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int s = 1; s < depth; s++) begin
                stage[s] <= stage[s-1];
            end
        end
    end

    assign dout = stage[depth-1];

endmodule

// File: src.f
logic/res_err_pkg.sv
logic/word_pipe.sv
logic/channel_filter.sv
logic/interval_timer.sv
logic/res_err_datapath.sv
logic/tap_adapter.sv
logic/adapt_ctrl.sv
logic/res_err_top.sv
testbench/tb_clk_gen.sv
testbench/res_err_assert.sv
testbench/res_err_tb.sv

// File: testbench/res_err_assert.sv
`timescale 1ns/10ps

module res_err_assert (
    input logic               clk,
    input logic               rst,
    input logic               adapt_en,
    input logic               err_valid,
    input res_err_pkg::taps_t taps
);

    import res_err_pkg::*;

    valid_low_after_reset: assert property (@(posedge clk) rst |=> !err_valid)
        else $error("err_valid high right after reset");

    valid_never_falls: assert property (@(posedge clk) (err_valid && !rst) |=> err_valid)
        else $error("err_valid fell without reset");

    frozen_taps: assert property (@(posedge clk) disable iff (rst)
        !adapt_en |=> $stable(taps))
        else $error("taps moved while adaptation was off");

    // One LSB per tap and cycle at most
    for (genvar j = 0; j < tap_count; j++) begin : step_chk
        tap_single_step: assert property (@(posedge clk) disable iff (rst)
            1'b1 |=> (taps[j] == $past(taps[j]) || taps[j] == $past(taps[j]) + tap_t'(1)
                      || taps[j] == $past(taps[j]) - tap_t'(1)))
            else $error("tap %0d stepped by more than one", j);
    end

endmodule

bind res_err_top res_err_assert assert_i (
    .clk       (clk),
    .rst       (rst),
    .adapt_en  (adapt_en),
    .err_valid (err_valid),
    .taps      (taps)
);

// File: testbench/res_err_tb.sv
`timescale 1ns/10ps

module res_err_tb;

    import res_err_pkg::*;

    localparam int random_words   = 200;
    localparam int directed_words = 4 * lane_count;
    localparam int adapt_words    = 6 * (adapt_period + 1) + 2;
    localparam int freeze_words   = 15 + 20 + 70;
    localparam int flush_words    = 4;
    localparam int run_cycles     = 2 + random_words + 2 * directed_words + adapt_words
                                    + freeze_words + flush_words;
    localparam int cycle_limit    = run_cycles + 50;
    localparam int hist_depth     = cycle_limit + 8;

    typedef enum {model_off, model_accum, model_apply} model_mode_t;

    logic       clk;
    logic       rst;
    logic       adapt_en;
    sym_word_t  sym_in;
    code_word_t code_in;
    err_word_t  err_out;
    sym_word_t  sym_out;
    logic       err_valid;
    taps_t      taps;

    integer      seed = 91;
    sym_word_t   sym_hist  [hist_depth];
    code_word_t  code_hist [hist_depth];
    taps_t       taps_hist [hist_depth];
    taps_t       model_taps;
    int          model_acc [tap_count];
    model_mode_t model_mode;
    int          model_words;
    logic        model_valid;
    int          low_edges;
    int          edge_cnt  = 0;
    int          cycle_cnt = 0;
    int          errors    = 0;
    int          chan_h1;
    int          chan_h2;

    tb_clk_gen clk_gen_i (.clk(clk));

    res_err_top uut (
        .clk       (clk),
        .rst       (rst),
        .sym_in    (sym_in),
        .code_in   (code_in),
        .adapt_en  (adapt_en),
        .err_out   (err_out),
        .sym_out   (sym_out),
        .err_valid (err_valid),
        .taps      (taps)
    );

    task automatic fail_now(input string msg);
        errors++;
        $display("ERR t=%0t %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_err(input err_word_t got, input err_word_t exp, input int n);
        for (int i = 0; i < lane_count; i++) begin
            if (got[i] !== exp[i]) begin
                fail_now($sformatf("err_out word %0d lane %0d: got %0d expected %0d",
                                   n, i, got[i], exp[i]));
            end
        end
    endtask

    task automatic check_sym(input sym_word_t got, input sym_word_t exp, input int n);
        if (got !== exp) begin
            fail_now($sformatf("sym_out word %0d: got %h expected %h", n, got, exp));
        end
    endtask

    task automatic check_taps(input taps_t got, input taps_t exp);
        for (int j = 0; j < tap_count; j++) begin
            if (got[j] !== exp[j]) begin
                fail_now($sformatf("tap %0d: got %0d expected %0d", j, got[j], exp[j]));
            end
        end
    endtask

    // Symbol at flattened stream position q
    function automatic sym_t sym_at(input int q);
        return sym_hist[q / lane_count][q % lane_count];
    endfunction

    // Estimate minus code for lane i of word n
    function automatic err_t ref_lane_err(input int n, input int i, input taps_t t);
        int p;
        int sum;
        int est;

        p   = lane_count * n + i;
        sum = 0;
        for (int j = 0; j < tap_count; j++) begin
            sum += int'(t[j]) * int'(sym_at(p + 1 - j));
        end
        est = sum >>> chan_shift;
        return err_t'(est - int'(code_hist[n][i]));
    endfunction

    function automatic err_word_t ref_err_word(input int n, input taps_t t);
        err_word_t w;

        for (int i = 0; i < lane_count; i++) begin
            w[i] = ref_lane_err(n, i, t);
        end
        return w;
    endfunction

    task automatic accumulate_corr(input int n, input taps_t t);
        err_t e;
        sym_t s;

        for (int j = 0; j < tap_count; j++) begin
            for (int i = 0; i < lane_count; i++) begin
                e = ref_lane_err(n, i, t);
                s = sym_at(lane_count * n + i + 1 - j);
                if ((e >= 0) == (s >= 0)) begin
                    model_acc[j]++;
                end else begin
                    model_acc[j]--;
                end
            end
        end
    endtask

    task automatic apply_model_step();
        for (int j = 0; j < tap_count; j++) begin
            if (model_acc[j] > 0 && model_taps[j] != tap_min) begin
                model_taps[j] = model_taps[j] - tap_t'(1);
            end else if (model_acc[j] < 0 && model_taps[j] != tap_max) begin
                model_taps[j] = model_taps[j] + tap_t'(1);
            end
            model_acc[j] = 0;
        end
    endtask

    // Model state across rising edge e
    task automatic model_edge(input int e, input logic r, input logic a);
        if (r) begin
            model_valid = 1'b0;
            low_edges   = 0;
            model_mode  = model_off;
            model_taps  = tap_init;
            foreach (model_acc[j]) model_acc[j] = 0;
        end else if (!model_valid) begin
            low_edges++;
            if (low_edges == fill_cycles + 1) begin
                model_valid = 1'b1;
            end
        end else begin
            case (model_mode)
                model_off: begin
                    foreach (model_acc[j]) model_acc[j] = 0;
                    if (a) begin
                        model_mode  = model_accum;
                        model_words = 0;
                    end
                end
                model_accum: begin
                    if (!a) begin
                        model_mode = model_off;
                    end else begin
                        // Output word in this cycle is word e-3
                        accumulate_corr(e - 3, taps_hist[e-2]);
                        model_words++;
                        if (model_words == adapt_period) begin
                            model_mode = model_apply;
                        end
                    end
                end
                default: begin
                    if (a) begin
                        apply_model_step();
                        model_mode  = model_accum;
                        model_words = 0;
                    end else begin
                        model_mode = model_off;
                    end
                end
            endcase
        end
    endtask

    // Record inputs and step the model on the edge, compare half a cycle later
    always begin
        int cur;

        @(posedge clk);
        cur = edge_cnt;
        sym_hist[cur]  = rst ? sym_word_t'('0) : sym_in;
        code_hist[cur] = rst ? code_word_t'('0) : code_in;
        model_edge(cur, rst, adapt_en);
        taps_hist[cur] = model_taps;
        edge_cnt++;
        @(negedge clk);
        if (err_valid !== model_valid) begin
            fail_now($sformatf("err_valid is %b, expected %b", err_valid, model_valid));
        end
        check_taps(taps, taps_hist[cur]);
        if (model_valid) begin
            check_err(err_out, ref_err_word(cur - 2, taps_hist[cur-1]), cur - 2);
            check_sym(sym_out, sym_hist[cur-2], cur - 2);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic sym_t rand_sym();
        int r;

        r = $random(seed);
        return sym_t'(2 * (r & 3) - 3);
    endfunction

    task automatic drive_word(input sym_word_t s, input code_word_t c, input logic en);
        @(posedge clk);
        #10;
        sym_in   = s;
        code_in  = c;
        adapt_en = en;
    endtask

    task automatic send_random(input int count);
        sym_word_t  w;
        code_word_t c;

        for (int k = 0; k < count; k++) begin
            for (int i = 0; i < lane_count; i++) begin
                w[i] = rand_sym();
                c[i] = code_t'($random(seed));
            end
            drive_word(w, c, 1'b0);
        end
    endtask

    // Codes from a causal channel 56, 24, -8 with a little noise
    task automatic send_channel(input int count, input logic en);
        sym_word_t  w;
        code_word_t c;
        int         s;

        for (int k = 0; k < count; k++) begin
            for (int i = 0; i < lane_count; i++) begin
                w[i] = rand_sym();
                s    = int'(w[i]);
                c[i] = code_t'((56 * s + 24 * chan_h1 - 8 * chan_h2 + $random(seed) % 2) >>> 2);
                chan_h2 = chan_h1;
                chan_h1 = s;
            end
            drive_word(w, c, en);
        end
    endtask

    // A lone symbol in each lane, surrounded by zero words
    task automatic send_directed();
        sym_word_t w;

        for (int k = 0; k < lane_count; k++) begin
            w    = '0;
            w[k] = (k % 2 == 1) ? sym_t'(-1) : sym_t'(3);
            drive_word(w, '0, 1'b0);
            repeat (3) drive_word('0, '0, 1'b0);
        end
    endtask

    initial begin
        rst      = 1'b1;
        adapt_en = 1'b0;
        sym_in   = '0;
        code_in  = '0;
        chan_h1  = 0;
        chan_h2  = 0;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;

        send_random(random_words);
        send_directed();
        send_channel(adapt_words, 1'b1);
        // Drop adaptation mid-interval, then resume
        send_channel(15, 1'b1);
        send_channel(20, 1'b0);
        send_channel(70, 1'b1);
        send_directed();
        repeat (flush_words) drive_word('0, '0, 1'b0);

        @(negedge clk);
        #1;
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule
